/* hash_io_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module hash_io_regs (
  input  wire                                     clk,
  input  wire                                     rst,

  input  wire                                     io_en,
  input  wire                                     io_wen,
  input  wire  [rss_hash_pkg::io_addr_width-1:0]  io_addr,
  input  wire  [rss_hash_pkg::io_data_width-1:0]  io_wr_data,
  output logic [rss_hash_pkg::io_data_width-1:0]  io_rd_data,
  output logic                                    io_rd_valid,

  output logic [rss_hash_pkg::io_data_width-1:0]  hash_data,
  output logic [1:0]                              hash_data_len,
  output logic                                    hash_data_valid,
  output logic                                    hash_clear,
  input  wire  [rss_hash_pkg::hash_width-1:0]     hash_out
);

  logic       wr_req;
  logic       rd_req;
  logic [7:0] word_offset;
  logic       clear_hit;
  logic       beat_hit;
  logic [1:0] beat_len;

  assign wr_req = io_en && io_wen;
  assign rd_req = io_en && !io_wen;

  // byte lanes and upper address bits are ignored.
  assign word_offset = {io_addr[7:2], 2'b00};

  always_comb begin
    clear_hit = 1'b0;
    beat_hit  = 1'b0;
    beat_len  = rss_hash_pkg::len_4b;
    case (word_offset)
      rss_hash_pkg::reg_clear: begin
        clear_hit = 1'b1;
      end
      rss_hash_pkg::reg_data1: begin
        beat_hit = 1'b1;
        beat_len = rss_hash_pkg::len_1b;
      end
      rss_hash_pkg::reg_data2: begin
        beat_hit = 1'b1;
        beat_len = rss_hash_pkg::len_2b;
      end
      rss_hash_pkg::reg_data4: begin
        beat_hit = 1'b1;
        beat_len = rss_hash_pkg::len_4b;
      end
      default: begin
        // undefined offset, write dropped.
        beat_hit = 1'b0;
      end
    endcase
  end

  // strobes.
  always_ff @(posedge clk) begin
    if (rst) begin
      hash_data_valid <= 1'b0;
      hash_clear      <= 1'b0;
      io_rd_valid     <= 1'b0;
    end else begin
      hash_data_valid <= wr_req && beat_hit;
      hash_clear      <= wr_req && clear_hit;
      io_rd_valid     <= rd_req;
    end
  end

  // payload.
  always_ff @(posedge clk) begin
    if (wr_req) begin
      hash_data <= io_wr_data;
    end
    if (wr_req && beat_hit) begin
      hash_data_len <= beat_len;
    end
    if (rd_req) begin
      io_rd_data <= hash_out;
    end
  end

  a_clear_beat_excl: assert property (
    @(posedge clk) disable iff (rst)
    !(hash_clear && hash_data_valid)
  );

endmodule

`default_nettype wire

/* rss_hash_accel.f */
+incdir+.
rss_hash_pkg.sv
toeplitz_key_window.sv
toeplitz_hash_acc.sv
hash_io_regs.sv
rss_hash_accel.sv
tb_rss_hash_accel.sv

/* rss_hash_accel.sv */
`timescale 1ns/1ps
`default_nettype none

module rss_hash_accel (
  input  wire                                     clk,
  input  wire                                     rst,

  // host i/o port.
  input  wire                                     io_en,
  input  wire                                     io_wen,
  input  wire  [rss_hash_pkg::io_strb_width-1:0]  io_strb,
  input  wire  [rss_hash_pkg::io_addr_width-1:0]  io_addr,
  input  wire  [rss_hash_pkg::io_data_width-1:0]  io_wr_data,
  output wire  [rss_hash_pkg::io_data_width-1:0]  io_rd_data,
  output wire                                     io_rd_valid
);

  // io_strb is not decoded, words are always taken whole.

  wire [rss_hash_pkg::io_data_width-1:0] hash_data;
  wire [1:0]                             hash_data_len;
  wire                                   hash_data_valid;
  wire                                   hash_clear;
  wire [rss_hash_pkg::hash_width-1:0]    hash_out;

  hash_io_regs u_io_regs (
    .clk             (clk),
    .rst             (rst),

    .io_en           (io_en),
    .io_wen          (io_wen),
    .io_addr         (io_addr),
    .io_wr_data      (io_wr_data),
    .io_rd_data      (io_rd_data),
    .io_rd_valid     (io_rd_valid),

    .hash_data       (hash_data),
    .hash_data_len   (hash_data_len),
    .hash_data_valid (hash_data_valid),
    .hash_clear      (hash_clear),
    .hash_out        (hash_out)
  );

  toeplitz_hash_acc u_hash_acc (
    .clk             (clk),
    .rst             (rst),

    .hash_data       (hash_data),
    .hash_data_len   (hash_data_len),
    .hash_data_valid (hash_data_valid),
    .hash_clear      (hash_clear),

    .hash_out        (hash_out)
  );

endmodule

`default_nettype wire

/* rss_hash_pkg.sv */
`default_nettype none

package rss_hash_pkg;

  // host i/o port.
  localparam int io_data_width = 32;
  localparam int io_strb_width = io_data_width / 8;
  localparam int io_addr_width = 22;

  // hash result.
  localparam int hash_width = 32;

  // rss key, most significant bit first.
  localparam int key_width = 320;
  localparam logic [key_width-1:0] toeplitz_key = {
    64'h6d5a56da255b0ec2,
    64'h4167253d43a38fb0,
    64'hd0ca2bcbae7b30b4,
    64'h77cb2da38030f20c,
    64'h6a42b73bbeac01fa
  };

  // last byte position with a full window.
  localparam int max_key_bytes = (key_width - hash_width) / 8;

  // position can overshoot by one 4-byte beat before it saturates.
  localparam int key_pos_width = $clog2(max_key_bytes + 5);

  // window seen by one beat: 32 input bits, each needing 32 key bits.
  localparam int window_width = 2 * hash_width - 1;

  // beat length codes.
  localparam logic [1:0] len_1b = 2'd1;
  localparam logic [1:0] len_2b = 2'd2;
  localparam logic [1:0] len_4b = 2'd0;

  // register byte offsets, decoded on address bits 7:2.
  localparam logic [7:0] reg_clear = 8'h00;
  localparam logic [7:0] reg_data1 = 8'h04;
  localparam logic [7:0] reg_data2 = 8'h08;
  localparam logic [7:0] reg_data4 = 8'h0C;

endpackage

`default_nettype wire

/* tb_toeplitz_model.svh */
`ifndef tb_toeplitz_model_svh
`define tb_toeplitz_model_svh

// standard rss key, first bit at the msb.
localparam logic [319:0] model_rss_key = {
  64'h6d5a56da255b0ec2,
  64'h4167253d43a38fb0,
  64'hd0ca2bcbae7b30b4,
  64'h77cb2da38030f20c,
  64'h6a42b73bbeac01fa
};

// room for the longest byte string the tests build.
localparam int model_vec_bits = 512;

// key bit n counted from the msb, zero past the key end.
function automatic logic key_bit_at(input int bit_pos);
  if (bit_pos < 320) begin
    return model_rss_key[319 - bit_pos];
  end
  return 1'b0;
endfunction

// byte 0 sits in the top 8 bits of data_vec.
function automatic logic [31:0] toeplitz_hash(input logic [model_vec_bits-1:0] data_vec,
                                              input int num_bytes);
  logic [31:0] result;
  logic [31:0] key_word;
  int          bit_pos;
  int          k;
  result = '0;
  for (bit_pos = 0; bit_pos < num_bytes * 8; bit_pos++) begin
    if (data_vec[model_vec_bits - 1 - bit_pos]) begin
      for (k = 0; k < 32; k++) begin
        key_word[31 - k] = key_bit_at(bit_pos + k);
      end
      result = result ^ key_word;
    end
  end
  return result;
endfunction

`endif

/* tb_rss_hash_accel.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rss_hash_accel;

  `include "tb_toeplitz_model.svh"

  localparam int rand_seed        = 33;
  localparam int num_streams      = 20;
  localparam int max_stream_bytes = 40;
  localparam int max_rows         = 32;

  logic                                    clk;
  logic                                    rst;
  logic                                    io_en;
  logic                                    io_wen;
  logic [rss_hash_pkg::io_strb_width-1:0]  io_strb;
  logic [rss_hash_pkg::io_addr_width-1:0]  io_addr;
  logic [rss_hash_pkg::io_data_width-1:0]  io_wr_data;
  wire  [rss_hash_pkg::io_data_width-1:0]  io_rd_data;
  wire                                     io_rd_valid;

  // stimulus table.
  logic        row_is_write  [0:max_rows-1];
  logic [7:0]  row_offset    [0:max_rows-1];
  logic [31:0] row_data      [0:max_rows-1];
  logic [31:0] row_expect    [0:max_rows-1];
  logic        row_use_model [0:max_rows-1];
  int          num_rows;

  // bytes the hash should have seen since the last clear.
  logic [model_vec_bits-1:0] model_vec;
  int                        model_len;
  int                        key_pos;

  logic failed;
  int   cycle_count;
  int   cycle_limit;

  rss_hash_accel u_dut (
    .clk        (clk),
    .rst        (rst),
    .io_en      (io_en),
    .io_wen     (io_wen),
    .io_strb    (io_strb),
    .io_addr    (io_addr),
    .io_wr_data (io_wr_data),
    .io_rd_data (io_rd_data),
    .io_rd_valid(io_rd_valid)
  );

  always #20 clk = ~clk;

  task automatic abort_run();
    failed = 1'b1;
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped on first failure");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s: got %h, expected %h", $time, msg, actual, expected);
      abort_run();
    end
  endtask

  task automatic add_row(input logic is_write, input logic [7:0] offset,
                         input logic [31:0] data, input logic [31:0] expected,
                         input logic use_model);
    row_is_write[num_rows]  = is_write;
    row_offset[num_rows]    = offset;
    row_data[num_rows]      = data;
    row_expect[num_rows]    = expected;
    row_use_model[num_rows] = use_model;
    num_rows++;
  endtask

  task automatic load_table();
    num_rows = 0;
    add_row(1'b0, 8'h00, 32'h0, 32'h0000_0000, 1'b0);
    // ipv4 addresses only.
    add_row(1'b1, rss_hash_pkg::reg_clear, 32'h0, 32'h0, 1'b0);
    add_row(1'b1, rss_hash_pkg::reg_data4, 32'h4209_95bb, 32'h0, 1'b0);
    add_row(1'b1, rss_hash_pkg::reg_data4, 32'ha18e_6450, 32'h0, 1'b0);
    add_row(1'b0, 8'h04, 32'h0, 32'h323e_8fc2, 1'b0);
    // ports 2794 and 1766 appended.
    add_row(1'b1, rss_hash_pkg::reg_data2, 32'h0aea_0000, 32'h0, 1'b0);
    add_row(1'b1, rss_hash_pkg::reg_data2, 32'h06e6_0000, 32'h0, 1'b0);
    add_row(1'b0, 8'h3c, 32'h0, 32'h51cc_c178, 1'b0);
    // same twelve bytes in mixed beats, junk in the unused lanes.
    add_row(1'b1, rss_hash_pkg::reg_clear, 32'h0, 32'h0, 1'b0);
    add_row(1'b1, rss_hash_pkg::reg_data1, 32'h4212_3456, 32'h0, 1'b0);
    add_row(1'b1, rss_hash_pkg::reg_data2, 32'h0995_beef, 32'h0, 1'b0);
    add_row(1'b1, rss_hash_pkg::reg_data4, 32'hbba1_8e64, 32'h0, 1'b0);
    add_row(1'b1, 8'h10, 32'hdead_beef, 32'h0, 1'b0);
    add_row(1'b1, rss_hash_pkg::reg_data1, 32'h50ff_ffff, 32'h0, 1'b0);
    add_row(1'b1, rss_hash_pkg::reg_data2, 32'h0aea_5555, 32'h0, 1'b0);
    add_row(1'b1, 8'h10, 32'h1234_5678, 32'h0, 1'b0);
    add_row(1'b1, rss_hash_pkg::reg_data1, 32'h0600_0000, 32'h0, 1'b0);
    add_row(1'b1, rss_hash_pkg::reg_data1, 32'he6ab_cdef, 32'h0, 1'b0);
    add_row(1'b0, 8'h08, 32'h0, 32'h51cc_c178, 1'b0);
    // clear, then vector again.
    add_row(1'b1, rss_hash_pkg::reg_clear, 32'h0, 32'h0, 1'b0);
    add_row(1'b0, 8'h00, 32'h0, 32'h0000_0000, 1'b0);
    add_row(1'b1, rss_hash_pkg::reg_data4, 32'h4209_95bb, 32'h0, 1'b0);
    add_row(1'b1, rss_hash_pkg::reg_data4, 32'ha18e_6450, 32'h0, 1'b0);
    add_row(1'b0, 8'h0c, 32'h0, 32'h323e_8fc2, 1'b0);
    add_row(1'b0, 8'h00, 32'h0, 32'h0, 1'b1);
  endtask

  // mirrors the register map: offset on bits 7:2, bytes from the top.
  task automatic track_write(input logic [21:0] addr, input logic [31:0] data);
    logic [7:0] offset;
    int         beat_bytes;
    int         k;
    offset     = {addr[7:2], 2'b00};
    beat_bytes = 0;
    case (offset)
      rss_hash_pkg::reg_clear: begin
        model_len = 0;
        key_pos   = 0;
      end
      rss_hash_pkg::reg_data1: beat_bytes = 1;
      rss_hash_pkg::reg_data2: beat_bytes = 2;
      rss_hash_pkg::reg_data4: beat_bytes = 4;
      default: beat_bytes = 0;
    endcase
    // a beat starting past the last full window adds nothing.
    if (beat_bytes > 0 && key_pos <= rss_hash_pkg::max_key_bytes) begin
      for (k = 0; k < beat_bytes; k++) begin
        model_vec[model_vec_bits - 1 - model_len * 8 -: 8] = data[31 - k * 8 -: 8];
        model_len++;
      end
      key_pos = key_pos + beat_bytes;
    end
  endtask

  task automatic write_reg(input logic [21:0] addr, input logic [31:0] data,
                           input logic [3:0] strb);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_addr    = addr;
    io_wr_data = data;
    io_strb    = strb;
    @(negedge clk);
    io_en  = 1'b0;
    io_wen = 1'b0;
    track_write(addr, data);
    repeat (2) @(negedge clk);
  endtask

  task automatic read_hash(input logic [21:0] addr, output logic [31:0] value);
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = addr;
    @(negedge clk);
    io_en = 1'b0;
    if (io_rd_valid !== 1'b1) begin
      $display("read response missing: no io_rd_valid after the read at %0t ns", $time);
      abort_run();
    end
    value = io_rd_data;
    @(negedge clk);
    check_value({31'b0, io_rd_valid}, 32'h0, "io_rd_valid longer than one cycle");
    @(negedge clk);
  endtask

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      abort_run();
    end
  end

  initial begin
    logic [31:0] rd_value;
    logic [31:0] rand_word;
    logic [31:0] rand_addr;
    logic [7:0]  beat_offset;
    int          row;
    int          stream;
    int          remaining;
    int          beat_bytes;
    clk         = 1'b0;
    rst         = 1'b1;
    io_en       = 1'b0;
    io_wen      = 1'b0;
    io_strb     = '0;
    io_addr     = '0;
    io_wr_data  = '0;
    failed      = 1'b0;
    cycle_count = 0;
    model_vec   = '0;
    model_len   = 0;
    key_pos     = 0;
    void'($urandom(rand_seed));
    load_table();
    cycle_limit = (num_rows + num_streams * (max_stream_bytes + 1) + num_streams) * 4
                  + 8 + 50;

    // sanity of the reference against the published vector.
    model_vec[model_vec_bits-1 -: 96] = 96'h420995bb_a18e6450_0aea06e6;
    check_value(toeplitz_hash(model_vec, 12), 32'h51cc_c178, "reference model");
    model_vec = '0;

    repeat (8) @(negedge clk);
    rst = 1'b0;

    for (row = 0; row < num_rows; row++) begin
      if (row_is_write[row]) begin
        write_reg({14'h0, row_offset[row]}, row_data[row], 4'hf);
      end else begin
        read_hash({14'h0, row_offset[row]}, rd_value);
        if (row_use_model[row]) begin
          check_value(rd_value, toeplitz_hash(model_vec, model_len),
                      $sformatf("table row %0d vs model", row));
        end else begin
          check_value(rd_value, row_expect[row], $sformatf("table row %0d", row));
        end
      end
    end

    // random streams, upper address bits and strobes vary freely.
    for (stream = 0; stream < num_streams; stream++) begin
      rand_addr = $urandom;
      write_reg({rand_addr[21:8], rss_hash_pkg::reg_clear}, $urandom, rand_addr[11:8]);
      remaining = $urandom % max_stream_bytes + 1;
      while (remaining > 0) begin
        case ($urandom % 3)
          0: beat_bytes = 1;
          1: beat_bytes = 2;
          default: beat_bytes = 4;
        endcase
        if (beat_bytes > remaining) begin
          beat_bytes = 1;
        end
        case (beat_bytes)
          1: beat_offset = rss_hash_pkg::reg_data1;
          2: beat_offset = rss_hash_pkg::reg_data2;
          default: beat_offset = rss_hash_pkg::reg_data4;
        endcase
        rand_word = $urandom;
        rand_addr = $urandom;
        write_reg({rand_addr[21:8], beat_offset}, rand_word, rand_addr[3:0]);
        remaining = remaining - beat_bytes;
      end
      rand_addr = $urandom;
      read_hash(rand_addr[21:0], rd_value);
      check_value(rd_value, toeplitz_hash(model_vec, model_len),
                  $sformatf("random stream %0d, %0d bytes hashed", stream, model_len));
    end

    if (!failed) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* toeplitz_hash_acc.sv */
`timescale 1ns/1ps
`default_nettype none

module toeplitz_hash_acc (
  input  wire                                     clk,
  input  wire                                     rst,

  input  wire  [rss_hash_pkg::io_data_width-1:0]  hash_data,
  input  wire  [1:0]                              hash_data_len,
  input  wire                                     hash_data_valid,
  input  wire                                     hash_clear,

  output logic [rss_hash_pkg::hash_width-1:0]     hash_out
);

  logic [rss_hash_pkg::window_width-1:0]  key_window;
  logic [rss_hash_pkg::io_data_width-1:0] len_mask;
  logic [rss_hash_pkg::io_data_width-1:0] beat_bits;
  logic [rss_hash_pkg::hash_width-1:0]    beat_hash;

  // key position advances by the same beat that is folded in.
  toeplitz_key_window u_key_window (
    .clk         (clk),
    .rst         (rst),
    .advance     (hash_data_valid),
    .advance_len (hash_data_len),
    .restart     (hash_clear),
    .key_window  (key_window)
  );

  // bytes are taken from the top of the word.
  always_comb begin
    case (hash_data_len)
      rss_hash_pkg::len_1b: begin
        len_mask = 32'hff00_0000;
      end
      rss_hash_pkg::len_2b: begin
        len_mask = 32'hffff_0000;
      end
      rss_hash_pkg::len_4b: begin
        len_mask = 32'hffff_ffff;
      end
      default: begin
        len_mask = '0;
      end
    endcase
  end

  assign beat_bits = hash_data & len_mask;

  // input bit i selects window bits i through i+31.
  always_comb begin
    beat_hash = '0;
    for (int i = 0; i < rss_hash_pkg::io_data_width; i++) begin
      if (beat_bits[rss_hash_pkg::io_data_width-1-i]) begin
        beat_hash = beat_hash ^
                    key_window[rss_hash_pkg::window_width-1-i -: rss_hash_pkg::hash_width];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      hash_out <= '0;
    end else if (hash_clear) begin
      hash_out <= '0;
    end else if (hash_data_valid) begin
      hash_out <= hash_out ^ beat_hash;
    end
  end

  // beats past the end of the key leave the hash alone.
  a_saturated_no_change: assert property (
    @(posedge clk) disable iff (rst)
    (hash_data_valid && !hash_clear &&
     (u_key_window.byte_pos > rss_hash_pkg::max_key_bytes))
    |=> $stable(hash_out)
  );

endmodule

`default_nettype wire

/* toeplitz_key_window.sv */
`timescale 1ns/1ps
`default_nettype none

module toeplitz_key_window (
  input  wire                                     clk,
  input  wire                                     rst,

  input  wire                                     advance,
  input  wire  [1:0]                              advance_len,
  input  wire                                     restart,

  output logic [rss_hash_pkg::window_width-1:0]   key_window
);

  // byte position into the key.
  logic [rss_hash_pkg::key_pos_width-1:0] byte_pos;
  logic [2:0]                             step_bytes;
  logic [rss_hash_pkg::key_width-1:0]     key_shifted;
  logic                                   pos_saturated;

  always_comb begin
    case (advance_len)
      rss_hash_pkg::len_1b: begin
        step_bytes = 3'd1;
      end
      rss_hash_pkg::len_2b: begin
        step_bytes = 3'd2;
      end
      rss_hash_pkg::len_4b: begin
        step_bytes = 3'd4;
      end
      default: begin
        step_bytes = 3'd0;
      end
    endcase
  end

  assign pos_saturated = (byte_pos > rss_hash_pkg::max_key_bytes);

  // once past the last full window the position stops moving.
  always_ff @(posedge clk) begin
    if (rst) begin
      byte_pos <= '0;
    end else if (restart) begin
      byte_pos <= '0;
    end else if (advance && !pos_saturated) begin
      byte_pos <= byte_pos + rss_hash_pkg::key_pos_width'(step_bytes);
    end
  end

  // left shift brings the current bit position to the msb.
  // vacated low bits are zero, so bits past the key end read as zero.
  assign key_shifted = rss_hash_pkg::toeplitz_key << {byte_pos, 3'b000};

  always_comb begin
    if (pos_saturated) begin
      key_window = '0;
    end else begin
      key_window = key_shifted[rss_hash_pkg::key_width-1 -: rss_hash_pkg::window_width];
    end
  end

  // a saturated position can only have been reached by one last beat.
  a_pos_bound: assert property (
    @(posedge clk) disable iff (rst)
    byte_pos <= rss_hash_pkg::max_key_bytes + 4
  );

endmodule

`default_nettype wire
